// ==== cpu_pkg.sv ====
package cpu_pkg;

    parameter int XLEN = 32;

    typedef logic [4:0] reg_addr_t;

    // R-type field layout
    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } inst_r_t;

    // I-type field layout
    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm16;
    } inst_i_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,
        ALU_LUI = 3'd6
    } alu_op_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        inst_u           inst;
    } fs_to_ds_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        alu_op_e         alu_op;
        logic [XLEN-1:0] src_a;
        logic [XLEN-1:0] src_b;
        reg_addr_t       dest;
        logic            wen;
    } ds_to_es_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic            wen;
        reg_addr_t       dest;
        logic [XLEN-1:0] result;
    } es_to_ws_t;

    typedef struct packed {
        logic            valid;
        logic            wen;
        reg_addr_t       dest;
        logic [XLEN-1:0] data;
    } fwd_t;

    typedef struct packed {
        logic            we;
        reg_addr_t       addr;
        logic [XLEN-1:0] data;
    } rf_write_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic            wen;
        reg_addr_t       wnum;
        logic [XLEN-1:0] wdata;
    } trace_t;

    // opcode field
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // funct field under OP_SPECIAL
    localparam logic [5:0] FUNCT_ADDU = 6'h21;
    localparam logic [5:0] FUNCT_SUBU = 6'h23;
    localparam logic [5:0] FUNCT_AND  = 6'h24;
    localparam logic [5:0] FUNCT_OR   = 6'h25;
    localparam logic [5:0] FUNCT_XOR  = 6'h26;
    localparam logic [5:0] FUNCT_SLT  = 6'h2a;

endpackage

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                        aclk,
    input  logic                        arst_n,
    input  cpu_pkg::reg_addr_t          rs_addr,
    input  cpu_pkg::reg_addr_t          rt_addr,
    output logic [cpu_pkg::XLEN-1:0]    rs_data,
    output logic [cpu_pkg::XLEN-1:0]    rt_data,
    input  cpu_pkg::rf_write_t          rf_write
);
    import cpu_pkg::*;

    logic [XLEN-1:0] regs [32];

    // register zero is never written, so it keeps its reset value
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (rf_write.we && (rf_write.addr != '0)) begin
            regs[rf_write.addr] <= rf_write.data;
        end
    end

    // combinational read ports
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

endmodule

// ==== fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage #(
    parameter logic [cpu_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                aclk,
    input  logic                arst_n,
    input  cpu_pkg::inst_u      inst,
    input  logic                inst_valid,
    output logic                fs_allowin,
    output logic                fs_to_ds_valid,
    output cpu_pkg::fs_to_ds_t  fs_to_ds,
    input  logic                ds_allowin
);
    import cpu_pkg::*;

    logic            fs_valid;
    logic            accept;
    logic [XLEN-1:0] pc_cnt;

    // empty, or handing the current word to decode this cycle
    assign fs_allowin     = !fs_valid || ds_allowin;
    assign accept         = inst_valid && fs_allowin;
    assign fs_to_ds_valid = fs_valid;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            fs_valid <= 1'b0;
            pc_cnt   <= RESET_PC;
        end else begin
            if (fs_allowin) begin
                fs_valid <= inst_valid;
            end
            if (accept) begin
                pc_cnt <= pc_cnt + XLEN'(4);
            end
        end
    end

    // word paired with the pc it was given
    always_ff @(posedge aclk) begin
        if (accept) begin
            fs_to_ds.pc   <= pc_cnt;
            fs_to_ds.inst <= inst;
        end
    end

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                        aclk,
    input  logic                        arst_n,
    input  logic                        fs_to_ds_valid,
    input  cpu_pkg::fs_to_ds_t          fs_to_ds,
    output logic                        ds_allowin,
    output cpu_pkg::reg_addr_t          rs_addr,
    output cpu_pkg::reg_addr_t          rt_addr,
    input  logic [cpu_pkg::XLEN-1:0]    rs_data,
    input  logic [cpu_pkg::XLEN-1:0]    rt_data,
    input  cpu_pkg::fwd_t               es_fwd,
    input  cpu_pkg::fwd_t               ws_fwd,
    output logic                        ds_to_es_valid,
    output cpu_pkg::ds_to_es_t          ds_to_es,
    input  logic                        es_allowin
);
    import cpu_pkg::*;

    logic            ds_valid;
    fs_to_ds_t       ds_item;
    inst_u           inst;
    logic [XLEN-1:0] rs_val;
    logic [XLEN-1:0] rt_val;
    logic [XLEN-1:0] imm_sext;
    logic [XLEN-1:0] imm_zext;

    // a bus only counts when it carries a real write to the same register
    function automatic logic fwd_hit(input fwd_t f, input reg_addr_t addr);
        return f.valid && f.wen && (f.dest != '0) && (f.dest == addr);
    endfunction

    function automatic logic [XLEN-1:0] pick_operand(
        input reg_addr_t       addr,
        input logic [XLEN-1:0] rf_data,
        input fwd_t            es,
        input fwd_t            ws
    );
        if (fwd_hit(es, addr)) begin
            return es.data;
        end
        if (fwd_hit(ws, addr)) begin
            return ws.data;
        end
        return rf_data;
    endfunction

    assign ds_allowin     = !ds_valid || es_allowin;
    assign ds_to_es_valid = ds_valid;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_item <= fs_to_ds;
        end
    end

    assign inst     = ds_item.inst;
    assign rs_addr  = inst.r.rs;
    assign rt_addr  = inst.r.rt;
    assign rs_val   = pick_operand(rs_addr, rs_data, es_fwd, ws_fwd);
    assign rt_val   = pick_operand(rt_addr, rt_data, es_fwd, ws_fwd);
    assign imm_sext = {{(XLEN-16){inst.i.imm16[15]}}, inst.i.imm16};
    assign imm_zext = {{(XLEN-16){1'b0}}, inst.i.imm16};

    always_comb begin
        ds_to_es.pc     = ds_item.pc;
        ds_to_es.alu_op = ALU_ADD;
        ds_to_es.src_a  = rs_val;
        ds_to_es.src_b  = rt_val;
        ds_to_es.dest   = inst.r.rd;
        ds_to_es.wen    = 1'b1;
        case (inst.r.opcode)
            OP_SPECIAL: begin
                case (inst.r.funct)
                    FUNCT_ADDU: ds_to_es.alu_op = ALU_ADD;
                    FUNCT_SUBU: ds_to_es.alu_op = ALU_SUB;
                    FUNCT_AND:  ds_to_es.alu_op = ALU_AND;
                    FUNCT_OR:   ds_to_es.alu_op = ALU_OR;
                    FUNCT_XOR:  ds_to_es.alu_op = ALU_XOR;
                    FUNCT_SLT:  ds_to_es.alu_op = ALU_SLT;
                    default:    ds_to_es.wen    = 1'b0;
                endcase
            end
            OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI: begin
                // I-type writes rt
                ds_to_es.dest  = inst.i.rt;
                ds_to_es.src_b = imm_zext;
                if (inst.i.opcode == OP_ADDIU) begin
                    ds_to_es.src_b = imm_sext;
                end
                if (inst.i.opcode == OP_ANDI) begin
                    ds_to_es.alu_op = ALU_AND;
                end
                if (inst.i.opcode == OP_ORI) begin
                    ds_to_es.alu_op = ALU_OR;
                end
                if (inst.i.opcode == OP_LUI) begin
                    ds_to_es.alu_op = ALU_LUI;
                end
            end
            default: ds_to_es.wen = 1'b0;
        endcase
    end

endmodule

// ==== exe_stage.sv ====
`timescale 1ns/1ps

module exe_stage (
    input  logic                aclk,
    input  logic                arst_n,
    input  logic                ds_to_es_valid,
    input  cpu_pkg::ds_to_es_t  ds_to_es,
    output logic                es_allowin,
    output cpu_pkg::fwd_t       es_fwd,
    output logic                es_to_ws_valid,
    output cpu_pkg::es_to_ws_t  es_to_ws,
    input  logic                ws_allowin
);
    import cpu_pkg::*;

    logic            es_valid;
    ds_to_es_t       es_item;
    logic [XLEN-1:0] alu_result;

    assign es_allowin     = !es_valid || ws_allowin;
    assign es_to_ws_valid = es_valid;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (ds_to_es_valid && es_allowin) begin
            es_item <= ds_to_es;
        end
    end

    always_comb begin
        case (es_item.alu_op)
            ALU_ADD: alu_result = es_item.src_a + es_item.src_b;
            ALU_SUB: alu_result = es_item.src_a - es_item.src_b;
            ALU_AND: alu_result = es_item.src_a & es_item.src_b;
            ALU_OR:  alu_result = es_item.src_a | es_item.src_b;
            ALU_XOR: alu_result = es_item.src_a ^ es_item.src_b;
            // signed compare, result is 0 or 1
            ALU_SLT: alu_result = XLEN'($signed(es_item.src_a) < $signed(es_item.src_b));
            ALU_LUI: alu_result = {es_item.src_b[15:0], 16'h0000};
            default: alu_result = '0;
        endcase
    end

    assign es_to_ws.pc     = es_item.pc;
    assign es_to_ws.wen    = es_item.wen;
    assign es_to_ws.dest   = es_item.dest;
    assign es_to_ws.result = alu_result;

    // result is ready in this stage, so decode can take it directly
    assign es_fwd.valid = es_valid;
    assign es_fwd.wen   = es_item.wen;
    assign es_fwd.dest  = es_item.dest;
    assign es_fwd.data  = alu_result;

endmodule

// ==== wb_stage.sv ====
`timescale 1ns/1ps

module wb_stage (
    input  logic                aclk,
    input  logic                arst_n,
    input  logic                es_to_ws_valid,
    input  cpu_pkg::es_to_ws_t  es_to_ws,
    output logic                ws_allowin,
    output cpu_pkg::fwd_t       ws_fwd,
    output cpu_pkg::rf_write_t  rf_write,
    output cpu_pkg::trace_t     trace,
    output logic                trace_valid,
    input  logic                trace_ready
);
    import cpu_pkg::*;

    logic      ws_valid;
    es_to_ws_t ws_item;

    // trace_ready low holds the item here and stalls the pipe
    assign ws_allowin  = !ws_valid || trace_ready;
    assign trace_valid = ws_valid;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= es_to_ws_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (es_to_ws_valid && ws_allowin) begin
            ws_item <= es_to_ws;
        end
    end

    assign trace.pc    = ws_item.pc;
    assign trace.wen   = ws_item.wen && (ws_item.dest != '0);
    assign trace.wnum  = ws_item.dest;
    assign trace.wdata = ws_item.result;

    // register file is written only when the trace item completes
    assign rf_write.we   = trace_valid && trace_ready && trace.wen;
    assign rf_write.addr = ws_item.dest;
    assign rf_write.data = ws_item.result;

    assign ws_fwd.valid = ws_valid;
    assign ws_fwd.wen   = ws_item.wen;
    assign ws_fwd.dest  = ws_item.dest;
    assign ws_fwd.data  = ws_item.result;

endmodule

// ==== cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top #(
    parameter logic [cpu_pkg::XLEN-1:0] RESET_PC = 32'hbfc0_0000
) (
    input  logic             aclk,
    input  logic             arst_n,
    input  cpu_pkg::inst_u   inst,
    input  logic             inst_valid,
    output logic             inst_ready,
    output cpu_pkg::trace_t  trace,
    output logic             trace_valid,
    input  logic             trace_ready
);
    import cpu_pkg::*;

    // stage handshakes
    logic ds_allowin;
    logic es_allowin;
    logic ws_allowin;
    logic fs_to_ds_valid;
    logic ds_to_es_valid;
    logic es_to_ws_valid;

    fs_to_ds_t fs_to_ds;
    ds_to_es_t ds_to_es;
    es_to_ws_t es_to_ws;

    // register file ports
    reg_addr_t       rs_addr;
    reg_addr_t       rt_addr;
    logic [XLEN-1:0] rs_data;
    logic [XLEN-1:0] rt_data;
    rf_write_t       rf_write;

    fwd_t es_fwd;
    fwd_t ws_fwd;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch_stage (
        .aclk           (aclk),
        .arst_n         (arst_n),
        .inst           (inst),
        .inst_valid     (inst_valid),
        .fs_allowin     (inst_ready),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds       (fs_to_ds),
        .ds_allowin     (ds_allowin)
    );

    decode_stage u_decode_stage (
        .aclk           (aclk),
        .arst_n         (arst_n),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds       (fs_to_ds),
        .ds_allowin     (ds_allowin),
        .rs_addr        (rs_addr),
        .rt_addr        (rt_addr),
        .rs_data        (rs_data),
        .rt_data        (rt_data),
        .es_fwd         (es_fwd),
        .ws_fwd         (ws_fwd),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es       (ds_to_es),
        .es_allowin     (es_allowin)
    );

    reg_file u_reg_file (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .rs_addr  (rs_addr),
        .rt_addr  (rt_addr),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .rf_write (rf_write)
    );

    exe_stage u_exe_stage (
        .aclk           (aclk),
        .arst_n         (arst_n),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es       (ds_to_es),
        .es_allowin     (es_allowin),
        .es_fwd         (es_fwd),
        .es_to_ws_valid (es_to_ws_valid),
        .es_to_ws       (es_to_ws),
        .ws_allowin     (ws_allowin)
    );

    wb_stage u_wb_stage (
        .aclk           (aclk),
        .arst_n         (arst_n),
        .es_to_ws_valid (es_to_ws_valid),
        .es_to_ws       (es_to_ws),
        .ws_allowin     (ws_allowin),
        .ws_fwd         (ws_fwd),
        .rf_write       (rf_write),
        .trace          (trace),
        .trace_valid    (trace_valid),
        .trace_ready    (trace_ready)
    );

endmodule

// ==== tb_cpu_top.sv ====
`timescale 1ns/1ps

module tb_cpu_top;
    import cpu_pkg::*;

    localparam logic [XLEN-1:0] RESET_PC   = 32'hbfc0_0000;
    localparam int              N_INST     = 2000;
    localparam int              MAX_CYCLES = 40000;

    logic     aclk;
    logic     arst_n;
    inst_u    inst;
    logic     inst_valid;
    logic     inst_ready;
    trace_t   trace;
    logic     trace_valid;
    logic     trace_ready;

    // reference model state, in program order
    logic [XLEN-1:0] model_regs [32];
    logic [XLEN-1:0] model_pc;
    trace_t          exp_q [$];
    int              accepted;
    int              retired;
    int              cycles;
    logic            running;
    logic            saw_full;

    cpu_top #(
        .RESET_PC (RESET_PC)
    ) dut0 (
        .aclk        (aclk),
        .arst_n      (arst_n),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .inst_ready  (inst_ready),
        .trace       (trace),
        .trace_valid (trace_valid),
        .trace_ready (trace_ready)
    );

    always #20 aclk = ~aclk;

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("Fail at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // words without a write only carry pc and a clear wen
    task automatic check_trace(input trace_t got, input trace_t exp);
        logic bad;
        bad = (got.pc !== exp.pc) || (got.wen !== exp.wen);
        if (exp.wen) begin
            bad = bad || (got.wnum !== exp.wnum) || (got.wdata !== exp.wdata);
        end
        if (bad) begin
            report_failure({
                $sformatf("Fail at %0t: trace pc=%h wen=%b wnum=%0d wdata=%h",
                    $time, got.pc, got.wen, got.wnum, got.wdata),
                $sformatf(", expected pc=%h wen=%b wnum=%0d wdata=%h",
                    exp.pc, exp.wen, exp.wnum, exp.wdata)});
        end
    endtask

    // low registers most of the time, so neighbours depend on each other
    function automatic reg_addr_t pick_reg();
        if ($urandom % 5 != 0) begin
            return reg_addr_t'($urandom % 4);
        end
        return reg_addr_t'($urandom % 32);
    endfunction

    function automatic logic [15:0] pick_imm();
        case ($urandom % 6)
            0: return 16'h8000;
            1: return 16'hffff;
            2: return 16'h7fff;
            default: return 16'($urandom);
        endcase
    endfunction

    function automatic inst_u gen_inst();
        inst_u       w;
        int unsigned kind;
        kind = $urandom % 12;
        w.r.opcode = OP_SPECIAL;
        w.r.rs     = pick_reg();
        w.r.rt     = pick_reg();
        w.r.rd     = pick_reg();
        w.r.shamt  = 5'd0;
        w.r.funct  = FUNCT_ADDU;
        case (kind)
            1: w.r.funct = FUNCT_SUBU;
            2: w.r.funct = FUNCT_AND;
            3: w.r.funct = FUNCT_OR;
            4: w.r.funct = FUNCT_XOR;
            5: w.r.funct = FUNCT_SLT;
            6: w.i.opcode = OP_ADDIU;
            7: w.i.opcode = OP_ANDI;
            8: w.i.opcode = OP_ORI;
            9: w.i.opcode = OP_LUI;
            // load/store opcode range, none of them retained
            10: w.r.opcode = 6'h20 | 6'($urandom % 16);
            // mult under special, not retained
            11: w.r.funct = 6'h18;
            default: w.r.funct = FUNCT_ADDU;
        endcase
        if (kind >= 6 && kind <= 9) begin
            w.i.imm16 = pick_imm();
        end
        return w;
    endfunction

    task automatic model_accept(input inst_u w);
        trace_t          exp;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm_s;
        logic [XLEN-1:0] imm_z;
        a     = model_regs[w.r.rs];
        b     = model_regs[w.r.rt];
        imm_s = {{16{w.i.imm16[15]}}, w.i.imm16};
        imm_z = {16'h0000, w.i.imm16};
        exp.pc    = model_pc;
        exp.wen   = 1'b1;
        exp.wnum  = w.i.rt;
        exp.wdata = '0;
        if (w.r.opcode == OP_SPECIAL) begin
            exp.wnum = w.r.rd;
            case (w.r.funct)
                FUNCT_ADDU: exp.wdata = a + b;
                FUNCT_SUBU: exp.wdata = a - b;
                FUNCT_AND:  exp.wdata = a & b;
                FUNCT_OR:   exp.wdata = a | b;
                FUNCT_XOR:  exp.wdata = a ^ b;
                FUNCT_SLT:  exp.wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default:    exp.wen   = 1'b0;
            endcase
        end else begin
            case (w.i.opcode)
                OP_ADDIU: exp.wdata = a + imm_s;
                OP_ANDI:  exp.wdata = a & imm_z;
                OP_ORI:   exp.wdata = a | imm_z;
                OP_LUI:   exp.wdata = {w.i.imm16, 16'h0000};
                default:  exp.wen   = 1'b0;
            endcase
        end
        // register zero stays zero
        if (exp.wnum == 5'd0) begin
            exp.wen = 1'b0;
        end
        if (exp.wen) begin
            model_regs[exp.wnum] = exp.wdata;
        end
        exp_q.push_back(exp);
        model_pc = model_pc + 32'd4;
    endtask

    initial begin
        void'($urandom(32'h8706));
        forever begin
            @(posedge aclk);
            if (running) begin
                if (!inst_ready) begin
                    saw_full = 1'b1;
                end
                if (inst_valid && inst_ready) begin
                    model_accept(inst);
                    accepted++;
                end
                if (trace_valid && trace_ready) begin
                    if (exp_q.size() == 0) begin
                        report_failure("trace item completed with no accepted word pending");
                    end
                    check_trace(trace, exp_q.pop_front());
                    retired++;
                end
                // a word may only change once it has transferred
                if (!inst_valid || inst_ready) begin
                    inst_valid <= (accepted < N_INST) && ($urandom % 4 != 0);
                    inst       <= gen_inst();
                end
                trace_ready <= ($urandom % 3) != 0;
            end
        end
    end

    initial begin
        aclk        = 1'b0;
        arst_n      = 1'b0;
        inst        = '0;
        inst_valid  = 1'b0;
        trace_ready = 1'b0;
        running     = 1'b0;
        saw_full    = 1'b0;
        accepted    = 0;
        retired     = 0;
        model_pc    = RESET_PC;
        for (int k = 0; k < 32; k++) begin
            model_regs[k] = '0;
        end
        repeat (8) @(posedge aclk);
        arst_n <= 1'b1;
        @(negedge aclk);
        check_bit(trace_valid, 1'b0, "trace_valid after reset");
        check_bit(inst_ready, 1'b1, "inst_ready after reset");
        running = 1'b1;
        cycles  = 0;
        while (retired < N_INST && cycles < MAX_CYCLES) begin
            @(negedge aclk);
            cycles++;
        end
        if (retired < N_INST) begin
            report_failure($sformatf("timeout: only %0d of %0d instructions retired",
                retired, N_INST));
        end else if (!saw_full) begin
            report_failure("inst_ready never fell, the pipeline was never backed up");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

// ==== flist.f ====
cpu_pkg.sv
reg_file.sv
fetch_stage.sv
decode_stage.sv
exe_stage.sv
wb_stage.sv
cpu_top.sv
tb_cpu_top.sv
